// File: Makefile
# Verilator build for the acquisition core testbench

VERILATOR ?= verilator
TOP       ?= tb_scope
DUT_TOP   ?= scope_top
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FLIST)) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: acq_trigger.sv
// trigger FSM with time-over-threshold qualification
// ring buffer write pointer, post-trigger and event counters
`timescale 1ns/1ns

module acq_trigger (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::sample_t     i_sample,
	input  scope_pkg::trig_cfg_t   i_cfg,
	input  logic                   i_arm,           // start a new event
	input  logic                   i_readout_done,  // release the held event
	output scope_pkg::acq_status_t o_status,
	output logic                   o_wr_en,
	output scope_pkg::addr_t       o_wr_addr,
	output scope_pkg::sample_t     o_wr_data
);

	scope_pkg::acq_state_t state;
	scope_pkg::trig_type_t kind_q;     // kind captured at arm
	scope_pkg::count_t     len_q;      // post length captured at arm
	scope_pkg::byte_t      tot_cnt;    // qualifying samples seen
	scope_pkg::addr_t      trig_addr;
	scope_pkg::count_t     event_cnt;
	scope_pkg::count_t     post_cnt;
	scope_pkg::addr_t      wr_next;    // slot the current sample goes to
	logic                  first_hit;  // arm1 condition
	logic                  qual_hit;   // arm2 condition

	assign wr_next = o_wr_en ? o_wr_addr + 1'b1 : o_wr_addr;

	// rising swaps the roles of the two thresholds
	always_comb begin
		if (kind_q == scope_pkg::TRIG_RISE) begin
			first_hit = i_sample > i_cfg.upper;
			qual_hit  = i_sample < i_cfg.lower;
		end else begin
			first_hit = i_sample < i_cfg.lower;
			qual_hit  = i_sample > i_cfg.upper;
		end
	end

	// write side
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			o_wr_en   <= 1'b0;
			o_wr_addr <= '0;
		end else begin
			o_wr_en <= (state != scope_pkg::ACQ_DONE);  // freeze buffer while held
			if (o_wr_en)
				o_wr_addr <= o_wr_addr + 1'b1;  // wraps at the top
		end
	end

	always_ff @(posedge clk) begin
		o_wr_data <= i_sample;
	end

	// trigger FSM
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state     <= scope_pkg::ACQ_IDLE;
			kind_q    <= scope_pkg::TRIG_NONE;
			len_q     <= '0;
			tot_cnt   <= '0;
			trig_addr <= '0;
			event_cnt <= '0;
			post_cnt  <= '0;
		end else begin
			case (state)
				scope_pkg::ACQ_IDLE: begin
					tot_cnt <= '0;
					if (i_arm) begin
						kind_q <= i_cfg.kind;
						len_q  <= i_cfg.post_len;
						if (i_cfg.kind == scope_pkg::TRIG_FALL ||
						    i_cfg.kind == scope_pkg::TRIG_RISE) begin
							state <= scope_pkg::ACQ_ARM1;
						end else begin
							trig_addr <= wr_next;  // free running, fire now
							state     <= scope_pkg::ACQ_POST;
						end
					end
				end
				scope_pkg::ACQ_ARM1: begin
					if (first_hit)
						state <= scope_pkg::ACQ_ARM2;
				end
				scope_pkg::ACQ_ARM2: begin
					if (qual_hit) begin
						if (tot_cnt >= i_cfg.tot) begin
							trig_addr <= wr_next;  // slot of this sample
							state     <= scope_pkg::ACQ_POST;
						end else begin
							tot_cnt <= tot_cnt + 1'b1;
						end
					end
				end
				scope_pkg::ACQ_POST: begin
					if (post_cnt < len_q) begin
						post_cnt <= post_cnt + 1'b1;
					end else begin
						event_cnt <= event_cnt + 1'b1;
						post_cnt  <= '1;  // marks event ready
						state     <= scope_pkg::ACQ_DONE;
					end
				end
				scope_pkg::ACQ_DONE: begin
					if (i_readout_done) begin
						post_cnt <= '0;
						state    <= scope_pkg::ACQ_IDLE;
					end
				end
				default: state <= scope_pkg::ACQ_IDLE;
			endcase
		end
	end

	assign o_status.trig_addr   = trig_addr;
	assign o_status.event_count = event_cnt;
	assign o_status.post_count  = post_cnt;
	assign o_status.ready       = (state == scope_pkg::ACQ_DONE);

endmodule

// File: cmd_engine.sv
// command execution: trigger settings, arm, version, event readout
// drives the 32-bit stream master with keep and last
// readout packs two samples per word from the ring buffer
`timescale 1ns/1ns

module cmd_engine (
	input  logic                   clk,
	input  logic                   rstn,
	input  scope_pkg::cmd_t        i_cmd,
	input  logic                   i_cmd_strobe,
	output logic                   o_cmd_done,      // reopens the receiver
	input  scope_pkg::acq_status_t i_status,
	output scope_pkg::trig_cfg_t   o_cfg,
	output logic                   o_arm,
	output logic                   o_readout_done,
	output scope_pkg::addr_t       o_rd_addr,
	input  scope_pkg::sample_t     i_rd_data,
	output logic                   o_tx_valid,
	output scope_pkg::word_t       o_tx_data,
	output logic [3:0]             o_tx_keep,
	output logic                   o_tx_last,
	input  logic                   i_tx_ready
);

	scope_pkg::eng_state_t state;
	scope_pkg::addr_t      pre_offset;  // samples shown before the trigger
	scope_pkg::word_t      rem;         // bytes still to send
	scope_pkg::sample_t    first_q;     // low sample of the word
	scope_pkg::word_t      const_word;  // single word answers
	scope_pkg::sample_t    thr_lo;
	scope_pkg::sample_t    thr_hi;
	logic                  is_const;
	logic                  tx_fire;

	// keep bits from the remaining byte count
	function automatic logic [3:0] keep_of(input scope_pkg::word_t left);
		case (left)
			32'd0:   keep_of = 4'b0000;
			32'd1:   keep_of = 4'b0001;
			32'd2:   keep_of = 4'b0011;
			32'd3:   keep_of = 4'b0111;
			default: keep_of = 4'b1111;
		endcase
	endfunction

	assign tx_fire = o_tx_valid && i_tx_ready;

	// thresholds, mid scale 128, 8 bit to 12 bit
	assign thr_lo = ((scope_pkg::sample_t'(i_cmd.b1) - scope_pkg::sample_t'(i_cmd.b2)
	                  - scope_pkg::sample_t'(128)) << 4) + scope_pkg::sample_t'(8);
	assign thr_hi = ((scope_pkg::sample_t'(i_cmd.b1) + scope_pkg::sample_t'(i_cmd.b2)
	                  - scope_pkg::sample_t'(128)) << 4) + scope_pkg::sample_t'(8);

	assign is_const = (i_cmd.opcode == scope_pkg::CMD_ARM) ||
	                  (i_cmd.opcode == scope_pkg::CMD_INFO) ||
	                  (i_cmd.opcode == scope_pkg::CMD_TRIG_SET);

	always_comb begin
		case (i_cmd.opcode)
			scope_pkg::CMD_ARM:
				const_word = {i_status.event_count, i_status.post_count};
			scope_pkg::CMD_INFO:
				const_word = (i_cmd.b1 == 8'd0) ? scope_pkg::word_t'(scope_pkg::FW_VERSION) : '0;
			scope_pkg::CMD_TRIG_SET:
				const_word = scope_pkg::word_t'(scope_pkg::CMD_TRIG_SET);  // echo opcode
			default:
				const_word = '0;
		endcase
	end

	// control FSM
	// --------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= scope_pkg::ENG_RX;
			o_cfg          <= '0;
			pre_offset     <= '0;
			rem            <= '0;
			o_rd_addr      <= '0;
			o_tx_valid     <= 1'b0;
			o_tx_keep      <= 4'b0000;
			o_tx_last      <= 1'b0;
			o_cmd_done     <= 1'b0;
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
		end else begin
			o_cmd_done     <= 1'b0;  // pulses
			o_arm          <= 1'b0;
			o_readout_done <= 1'b0;
			case (state)
				scope_pkg::ENG_RX: begin
					if (i_cmd_strobe) begin
						case (i_cmd.opcode)
							scope_pkg::CMD_READ: begin
								rem   <= {i_cmd.b7, i_cmd.b6, i_cmd.b5, i_cmd.b4};
								state <= scope_pkg::ENG_EXEC;
							end
							scope_pkg::CMD_ARM: begin
								o_cfg.kind     <= scope_pkg::trig_type_t'(i_cmd.b1[1:0]);
								o_cfg.post_len <= {i_cmd.b5, i_cmd.b4};
								o_arm          <= (i_status.post_count == '0);  // no event pending
							end
							scope_pkg::CMD_TRIG_SET: begin
								o_cfg.lower <= thr_lo;
								o_cfg.upper <= thr_hi;
								o_cfg.tot   <= i_cmd.b5;
								pre_offset  <= {i_cmd.b3[1:0], i_cmd.b4};
							end
							scope_pkg::CMD_INFO: begin
								rem <= '0;  // answer only
							end
							default: begin
								o_cmd_done <= 1'b1;  // unknown, drop it
							end
						endcase
						if (is_const) begin
							o_tx_valid <= 1'b1;
							o_tx_keep  <= 4'b1111;
							o_tx_last  <= 1'b1;
							state      <= scope_pkg::ENG_TX_CONST;
						end
					end
				end
				scope_pkg::ENG_TX_CONST: begin
					if (tx_fire) begin
						o_tx_valid <= 1'b0;
						o_tx_last  <= 1'b0;
						o_cmd_done <= 1'b1;
						state      <= scope_pkg::ENG_RX;
					end
				end
				scope_pkg::ENG_EXEC: begin
					o_rd_addr <= i_status.trig_addr - pre_offset;  // wraps in the ring
					if (rem == '0) begin
						o_cmd_done     <= 1'b1;  // empty readout
						o_readout_done <= i_status.ready;
						state          <= scope_pkg::ENG_RX;
					end else begin
						state <= scope_pkg::ENG_RD_ADDR;
					end
				end
				scope_pkg::ENG_RD_ADDR: begin
					o_rd_addr <= o_rd_addr + 1'b1;  // second sample
					state     <= scope_pkg::ENG_RD_WAIT;
				end
				scope_pkg::ENG_RD_WAIT: begin
					state <= scope_pkg::ENG_TX_DATA;  // first sample on ram output
				end
				scope_pkg::ENG_TX_DATA: begin
					if (!o_tx_valid) begin
						o_tx_valid <= 1'b1;  // word loaded this edge
						o_tx_keep  <= keep_of(rem);
						o_tx_last  <= (rem <= 32'd4);
						o_rd_addr  <= o_rd_addr + 1'b1;  // next word start
					end else if (i_tx_ready) begin
						o_tx_valid <= 1'b0;
						o_tx_last  <= 1'b0;
						if (rem <= 32'd4) begin
							o_cmd_done     <= 1'b1;
							o_readout_done <= i_status.ready;  // free the buffer
							state          <= scope_pkg::ENG_RX;
						end else begin
							rem   <= rem - 32'd4;
							state <= scope_pkg::ENG_RD_ADDR;
						end
					end
				end
				default: state <= scope_pkg::ENG_RX;
			endcase
		end
	end

	// payload
	// --------------------
	always_ff @(posedge clk) begin
		if (state == scope_pkg::ENG_RD_WAIT)
			first_q <= i_rd_data;
		if (state == scope_pkg::ENG_RX && i_cmd_strobe)
			o_tx_data <= const_word;
		else if (state == scope_pkg::ENG_TX_DATA && !o_tx_valid)
			o_tx_data <= {4'b0000, i_rd_data, 4'b0000, first_q};  // 2nd high, 1st low
	end

endmodule

// File: cmd_receiver.sv
// byte-wide stream slave collecting one 8-byte command
// strobes the record and blocks input until the engine is done
`timescale 1ns/1ns

module cmd_receiver (
	input  logic             clk,
	input  logic             rstn,
	input  logic             i_rx_valid,
	input  scope_pkg::byte_t i_rx_data,
	output logic             o_rx_ready,
	input  logic             i_cmd_done,    // engine finished the command
	output scope_pkg::cmd_t  o_cmd,
	output logic             o_cmd_strobe
);

	logic [$clog2(scope_pkg::CMD_BYTES)-1:0] byte_cnt;  // bytes taken so far
	logic                                    rx_fire;
	logic                                    last_byte;

	assign rx_fire   = i_rx_valid && o_rx_ready;  // byte handshake
	assign last_byte = (int'(byte_cnt) == scope_pkg::CMD_BYTES - 1);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt     <= '0;
			o_rx_ready   <= 1'b1;  // open for the first command
			o_cmd_strobe <= 1'b0;
		end else begin
			o_cmd_strobe <= 1'b0;  // single cycle pulse
			if (rx_fire) begin
				if (last_byte) begin
					byte_cnt     <= '0;
					o_rx_ready   <= 1'b0;  // hold off while executing
					o_cmd_strobe <= 1'b1;
				end else begin
					byte_cnt <= byte_cnt + 1'b1;
				end
			end
			if (i_cmd_done)
				o_rx_ready <= 1'b1;
		end
	end

	// shift in, so byte 0 ends up as the opcode
	always_ff @(posedge clk) begin
		if (rx_fire)
			o_cmd <= scope_pkg::cmd_t'({o_cmd[$bits(scope_pkg::cmd_t)-9:0], i_rx_data});
	end

endmodule

// File: flist.f
scope_pkg.sv
cmd_receiver.sv
acq_trigger.sv
sample_ram.sv
cmd_engine.sv
scope_top.sv
scope_asserts.sv
tb_scope.sv

// File: sample_ram.sv
// 1024 x 12 sample ring buffer
// one write port, one read port with registered data
`timescale 1ns/1ns

module sample_ram (
	input  logic               clk,
	input  logic               i_wr_en,
	input  scope_pkg::addr_t   i_wr_addr,
	input  scope_pkg::sample_t i_wr_data,
	input  scope_pkg::addr_t   i_rd_addr,
	output scope_pkg::sample_t o_rd_data
);

	scope_pkg::sample_t mem [2**scope_pkg::ADDR_W];  // block ram

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// data one cycle after the address
	always_ff @(posedge clk) begin
		o_rd_data <= mem[i_rd_addr];  // old data on collision
	end

endmodule

// File: scope_asserts.sv
// stream handshake and command hold-off checks for scope_top
`timescale 1ns/1ns

module scope_asserts (
	input logic             clk,
	input logic             rstn,
	input logic             o_tx_valid,
	input scope_pkg::word_t o_tx_data,
	input logic [3:0]       o_tx_keep,
	input logic             o_tx_last,
	input logic             i_tx_ready,
	input logic             o_rx_ready,
	input logic             cmd_done
);

	// word master holds its beat until taken
	a_valid_hold: assert property (@(posedge clk) disable iff (!rstn)
		o_tx_valid && !i_tx_ready |=> o_tx_valid)
		else $error("tx valid dropped before accept");

	a_data_stable: assert property (@(posedge clk) disable iff (!rstn)
		o_tx_valid && !i_tx_ready |=> $stable({o_tx_data, o_tx_keep, o_tx_last}))
		else $error("tx beat changed under stall");

	// receiver closed while a command runs
	a_tx_closed: assert property (@(posedge clk) disable iff (!rstn)
		o_tx_valid |-> !o_rx_ready)
		else $error("rx ready high while a response is sent");

	a_done_closed: assert property (@(posedge clk) disable iff (!rstn)
		cmd_done |-> !o_rx_ready)
		else $error("command done pulse without a pending command");

endmodule

bind scope_top scope_asserts u_asserts (
	.clk(clk), .rstn(rstn),
	.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
	.o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready), .o_rx_ready(o_rx_ready),
	.cmd_done(cmd_done)
);

// File: scope_pkg.sv
// widths, opcodes and version of the acquisition core
// shared vector types, command record, trigger config and status structs
// state encodings of the trigger and command FSMs
package scope_pkg;

	// sizes
	// --------------------
	localparam int SAMPLE_W   = 12;  // adc sample bits
	localparam int ADDR_W     = 10;  // 1024 entry ring buffer
	localparam int CMD_BYTES  = 8;   // bytes per command
	localparam int FW_VERSION = 17;  // answered by info cmd

	typedef logic signed [SAMPLE_W-1:0] sample_t;  // signed adc code
	typedef logic        [ADDR_W-1:0]   addr_t;    // ring buffer index
	typedef logic        [15:0]         count_t;   // event / post counters
	typedef logic        [31:0]         word_t;    // one response beat
	typedef logic        [7:0]          byte_t;    // one command byte

	// opcodes
	// --------------------
	localparam byte_t CMD_READ     = 8'd0;  // stream event out
	localparam byte_t CMD_ARM      = 8'd1;  // arm + status
	localparam byte_t CMD_INFO     = 8'd2;  // version
	localparam byte_t CMD_TRIG_SET = 8'd8;  // thresholds, offset, tot

	// byte 0 lands in the top bits
	typedef struct packed {
		byte_t opcode;
		byte_t b1;
		byte_t b2;
		byte_t b3;
		byte_t b4;
		byte_t b5;
		byte_t b6;
		byte_t b7;
	} cmd_t;

	typedef enum logic [1:0] {
		TRIG_NONE = 2'd0,  // fire on arm
		TRIG_FALL = 2'd1,  // below lower, then above upper
		TRIG_RISE = 2'd2   // above upper, then below lower
	} trig_type_t;

	typedef struct packed {
		sample_t    lower;     // low threshold
		sample_t    upper;     // high threshold
		byte_t      tot;       // time over threshold, samples
		trig_type_t kind;
		count_t     post_len;  // samples kept after the trigger
	} trig_cfg_t;

	typedef struct packed {
		addr_t  trig_addr;    // buffer slot of the trigger sample
		count_t event_count;
		count_t post_count;   // all ones once the event is held
		logic   ready;        // event waiting for readout
	} acq_status_t;

	// FSM encodings
	// --------------------
	typedef enum logic [2:0] {
		ACQ_IDLE, ACQ_ARM1, ACQ_ARM2, ACQ_POST, ACQ_DONE
	} acq_state_t;

	typedef enum logic [2:0] {
		ENG_RX, ENG_EXEC, ENG_TX_CONST, ENG_RD_ADDR, ENG_RD_WAIT, ENG_TX_DATA
	} eng_state_t;

endpackage

// File: scope_top.sv
// acquisition core top level
// command receiver, trigger, ring buffer and command engine
`timescale 1ns/1ns

module scope_top (
	input  logic               clk,
	input  logic               rstn,
	// byte stream slave
	input  logic               i_rx_valid,
	input  scope_pkg::byte_t   i_rx_data,
	output logic               o_rx_ready,
	// word stream master
	output logic               o_tx_valid,
	output scope_pkg::word_t   o_tx_data,
	output logic [3:0]         o_tx_keep,
	output logic               o_tx_last,
	input  logic               i_tx_ready,
	// adc samples, one per clk
	input  scope_pkg::sample_t i_sample
);

	scope_pkg::cmd_t        cmd;
	logic                   cmd_strobe;
	logic                   cmd_done;
	scope_pkg::trig_cfg_t   cfg;
	logic                   arm;
	logic                   readout_done;
	scope_pkg::acq_status_t status;
	logic                   wr_en;
	scope_pkg::addr_t       wr_addr;
	scope_pkg::sample_t     wr_data;
	scope_pkg::addr_t       rd_addr;
	scope_pkg::sample_t     rd_data;

	cmd_receiver u_rx (
		.clk(clk), .rstn(rstn),
		.i_rx_valid(i_rx_valid), .i_rx_data(i_rx_data), .o_rx_ready(o_rx_ready),
		.i_cmd_done(cmd_done), .o_cmd(cmd), .o_cmd_strobe(cmd_strobe)
	);

	acq_trigger u_trig (
		.clk(clk), .rstn(rstn), .i_sample(i_sample), .i_cfg(cfg),
		.i_arm(arm), .i_readout_done(readout_done), .o_status(status),
		.o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_data(wr_data)
	);

	sample_ram u_ram (
		.clk(clk), .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_addr(rd_addr), .o_rd_data(rd_data)
	);

	cmd_engine u_eng (
		.clk(clk), .rstn(rstn), .i_cmd(cmd), .i_cmd_strobe(cmd_strobe),
		.o_cmd_done(cmd_done), .i_status(status), .o_cfg(cfg), .o_arm(arm),
		.o_readout_done(readout_done), .o_rd_addr(rd_addr), .i_rd_data(rd_data),
		.o_tx_valid(o_tx_valid), .o_tx_data(o_tx_data), .o_tx_keep(o_tx_keep),
		.o_tx_last(o_tx_last), .i_tx_ready(i_tx_ready)
	);

endmodule

// File: scope_vectors.txt
# kind name f0..f8 in hex. C: 8 cmd bytes, expected word. W: level, cycles. P: poll bytes, events
# R: byte length, sample check flag, word0 low/high sample, word1 low/high sample
C version   02 00 00 00 00 00 00 00 11
C trig_set  08 80 20 00 06 03 00 00 08
C arm_none  01 00 00 00 14 00 00 00 0
P event_one 01 00 00 00 14 00 00 00 1
R read_keep 0a 0 0 0 0 0 0 0 0
C arm_rise  01 02 00 00 28 00 00 00 10000
W idle      000 0a 0 0 0 0 0 0 0
W high      400 14 0 0 0 0 0 0 0
W low       c00 1e 0 0 0 0 0 0 0
P event_two 01 02 00 00 28 00 00 00 2
R read_trig 10 1 400 400 400 c00 0 0 0

// File: tb_scope.sv
// testbench for the acquisition core
// vector driven steps, random tx back-pressure, compare tasks, watchdog
`timescale 1ns/1ns

module tb_scope;

	logic               clk;
	logic               rstn;
	logic               i_rx_valid;
	scope_pkg::byte_t   i_rx_data;
	logic               o_rx_ready;
	logic               o_tx_valid;
	scope_pkg::word_t   o_tx_data;
	logic [3:0]         o_tx_keep;
	logic               o_tx_last;
	logic               i_tx_ready;
	scope_pkg::sample_t i_sample;

	integer seed = 26192;
	int     errors;
	int     tests;
	int     n_rec;
	int     wd_cycles;            // watchdog budget set once vectors are loaded
	string  kinds [32];           // C cmd, W waveform, P poll, R readout
	string  names [32];
	logic [31:0] fld [32][9];     // hex fields of each step

	scope_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// random stall on the word output
	initial begin
		i_tx_ready = 1'b0;
		forever begin
			@(posedge clk);
			#1 i_tx_ready = (($random(seed) & 3) != 0);
		end
	end

	initial begin
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("timeout: no finish within %0d cycles", wd_cycles);
		$display("Done: errors found");
		$finish;
	end

	// compare tasks
	// --------------------
	task automatic check_word(input string nm, input scope_pkg::word_t e, input scope_pkg::word_t a);
		if (e !== a) begin
			$display("MISMATCH %s: expected %h, actual %h", nm, e, a);
			errors++;
		end
	endtask

	task automatic check_sample(input string nm, input scope_pkg::sample_t e,
	                            input scope_pkg::sample_t a);
		if (e !== a) begin
			$display("MISMATCH %s sample: expected %h, actual %h", nm, e, a);
			errors++;
		end
	endtask

	task automatic check_count(input string nm, input scope_pkg::count_t e,
	                           input scope_pkg::count_t a);
		if (e !== a) begin
			$display("MISMATCH %s count: expected %0d, actual %0d", nm, e, a);
			errors++;
		end
	endtask

	task automatic check_flags(input string nm, input logic [4:0] e, input logic [4:0] a);
		if (e !== a) begin
			$display("MISMATCH %s last/keep: expected %b, actual %b", nm, e, a);
			errors++;
		end
	endtask

	// expected {last, keep} from the bytes still to send
	function automatic logic [4:0] flags_for(input int left);
		if (left >= 4)
			flags_for = {left == 4, 4'b1111};
		else
			flags_for = {1'b1, 4'((1 << left) - 1)};
	endfunction

	function automatic scope_pkg::cmd_t rec_cmd(input int r);
		logic [63:0] c;
		for (int i = 0; i < 8; i++)
			c[63-8*i -: 8] = fld[r][i][7:0];
		rec_cmd = scope_pkg::cmd_t'(c);
	endfunction

	// bus tasks
	// --------------------
	task automatic send_cmd(input scope_pkg::cmd_t c);
		logic [63:0] cv;
		cv = c;
		for (int i = 0; i < 8; i++) begin
			i_rx_valid = 1'b1;
			i_rx_data  = cv[63-8*i -: 8];  // opcode first
			@(negedge clk);
			while (!o_rx_ready)
				@(negedge clk);
			@(posedge clk);
			#1;
		end
		i_rx_valid = 1'b0;
	endtask

	task automatic recv_word(output scope_pkg::word_t d, output logic [4:0] kl);
		@(negedge clk);
		while (!(o_tx_valid && i_tx_ready))
			@(negedge clk);
		d  = o_tx_data;
		kl = {o_tx_last, o_tx_keep};
		@(posedge clk);
		#1;
	endtask

	// steps
	// --------------------
	task automatic run_step(input int r);
		scope_pkg::word_t d;
		logic [4:0]       kl;
		int               left;
		int               nw;
		if (kinds[r] == "C") begin
			send_cmd(rec_cmd(r));
			recv_word(d, kl);
			check_word(names[r], fld[r][8], d);
			check_flags(names[r], 5'b11111, kl);
		end else if (kinds[r] == "W") begin
			i_sample = scope_pkg::sample_t'(fld[r][0]);
			repeat (fld[r][1]) @(posedge clk);
			#1;
		end else if (kinds[r] == "P") begin
			d = '0;
			while (d[15:0] !== 16'hffff) begin  // until the event is held
				send_cmd(rec_cmd(r));
				recv_word(d, kl);
			end
			check_count(names[r], fld[r][8][15:0], d[31:16]);
		end else if (kinds[r] == "R") begin
			send_cmd(scope_pkg::cmd_t'({32'd0, fld[r][0][7:0], fld[r][0][15:8],
			                             fld[r][0][23:16], fld[r][0][31:24]}));
			left = fld[r][0];
			nw   = 0;
			kl   = '0;
			while (!kl[4]) begin
				recv_word(d, kl);
				check_flags(names[r], flags_for(left), kl);
				if (fld[r][1] != 0 && nw < 2) begin
					check_sample(names[r], fld[r][2+2*nw][11:0], d[11:0]);
					check_sample(names[r], fld[r][3+2*nw][11:0], d[27:16]);
				end
				left -= 4;
				nw++;
			end
			check_count(names[r], scope_pkg::count_t'((fld[r][0] + 3) / 4),
			            scope_pkg::count_t'(nw));
		end else begin
			$display("step %s has an unknown kind %s", names[r], kinds[r]);
			errors++;
		end
	endtask

	initial begin
		int    fd;
		int    errs0;
		int    wave;
		string line;
		rstn       = 1'b0;
		i_rx_valid = 1'b0;
		i_rx_data  = '0;
		i_sample   = '0;
		errors     = 0;
		tests      = 0;
		n_rec      = 0;
		wave       = 0;
		wd_cycles  = 0;
		fd = $fopen("scope_vectors.txt", "r");
		if (fd == 0) begin
			$display("vector file scope_vectors.txt could not be opened");
			$display("Done: errors found");
			$finish;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 2 && line[0] != "#" && n_rec < 32) begin
					void'($sscanf(line, "%s %s %h %h %h %h %h %h %h %h %h",
					              kinds[n_rec], names[n_rec], fld[n_rec][0], fld[n_rec][1],
					              fld[n_rec][2], fld[n_rec][3], fld[n_rec][4], fld[n_rec][5],
					              fld[n_rec][6], fld[n_rec][7], fld[n_rec][8]));
					if (kinds[n_rec] == "W")
						wave += fld[n_rec][1];
					n_rec++;
				end
			end
			$fclose(fd);
			wd_cycles = 16 + wave + 200 * n_rec;
			repeat (16) @(posedge clk);
			#1 rstn = 1'b1;
			@(posedge clk);
			#1;
			for (int r = 0; r < n_rec; r++) begin
				errs0 = errors;
				run_step(r);
				tests++;
				$display("test %s: %s", names[r], (errors == errs0) ? "ok" : "FAILED");
			end
			$display("tests %0d, errors %0d", tests, errors);
			if (errors == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule
